//--- design/div_pkg.sv
// shared widths and enums for the divide unit, imported by every RTL module
`default_nettype none

package div_pkg;

    // operand and result width, fixed by the instruction set
    localparam int data_width = 32;

    // leading-zero counts and round counters, 0 to 32
    localparam int count_width = 6;

    // SRT core sequencing
    typedef enum logic [1:0] {
        st_waiting   = 2'b00,
        st_normalize = 2'b01,
        st_dividing  = 2'b10,
        st_finished  = 2'b11
    } srt_state_t;

    // result select, taken from the slot's mod bit
    typedef enum logic {
        op_quot = 1'b0,
        op_rem  = 1'b1
    } div_op_t;

endpackage

`default_nettype wire

//--- design/leading_zero_count.sv
// combinational leading-zero counter for a 32-bit word, used to normalize SRT operands
`timescale 1ns/1ns
`default_nettype none

module leading_zero_count import div_pkg::*; (
    input  logic [data_width-1:0]  data,
    output logic [count_width-1:0] zero_count
);

    logic [data_width-1:0] stage_16;
    logic [data_width-1:0] stage_8;
    logic [data_width-1:0] stage_4;
    logic [data_width-1:0] stage_2;
    logic [4:0]            zeros;
    logic                  all_zero;

    // halve the search window each level, one count bit per level
    assign zeros[4]  = ~|data[31:16];
    assign stage_16  = zeros[4] ? {data[15:0], 16'd0} : data;

    assign zeros[3]  = ~|stage_16[31:24];
    assign stage_8   = zeros[3] ? {stage_16[23:0], 8'd0} : stage_16;

    assign zeros[2]  = ~|stage_8[31:28];
    assign stage_4   = zeros[2] ? {stage_8[27:0], 4'd0} : stage_8;

    assign zeros[1]  = ~|stage_4[31:30];
    assign stage_2   = zeros[1] ? {stage_4[29:0], 2'd0} : stage_4;

    // last level is a single bit
    assign zeros[0]  = ~stage_2[31];

    assign all_zero  = ~|data;

    // empty word reads as the full width
    always_comb begin
        if (all_zero) begin
            zero_count = count_width'(data_width);
        end else begin
            zero_count = {1'b0, zeros};
        end
    end

endmodule

`default_nettype wire

//--- design/div_request_select.sv
// producer stage: picks one of two slot requests and turns it into magnitudes and signs
`timescale 1ns/1ns
`default_nettype none

module div_request_select import div_pkg::*; (
    input  logic                  req1_div,
    input  logic                  req1_mod,
    input  logic                  req1_unsigned,
    input  logic [data_width-1:0] req1_x,
    input  logic [data_width-1:0] req1_y,
    input  logic                  req2_div,
    input  logic                  req2_mod,
    input  logic                  req2_unsigned,
    input  logic [data_width-1:0] req2_x,
    input  logic [data_width-1:0] req2_y,
    output logic                  go,
    output div_op_t               op,
    output logic [data_width-1:0] x_mag,
    output logic [data_width-1:0] y_mag,
    output logic [data_width-1:0] dividend,
    output logic                  q_neg,
    output logic                  r_neg
);

    logic                  sel_div;
    logic                  sel_mod;
    logic                  sel_unsigned;
    logic [data_width-1:0] sel_x;
    logic [data_width-1:0] sel_y;
    logic                  x_neg;
    logic                  y_neg;

    // slot 1 always wins
    always_comb begin
        if (req1_div) begin
            sel_div      = 1'b1;
            sel_mod      = req1_mod;
            sel_unsigned = req1_unsigned;
            sel_x        = req1_x;
            sel_y        = req1_y;
        end else if (req2_div) begin
            sel_div      = 1'b1;
            sel_mod      = req2_mod;
            sel_unsigned = req2_unsigned;
            sel_x        = req2_x;
            sel_y        = req2_y;
        end else begin
            sel_div      = 1'b0;
            sel_mod      = 1'b0;
            sel_unsigned = 1'b0;
            sel_x        = '0;
            sel_y        = '0;
        end
    end

    assign x_neg = ~sel_unsigned & sel_x[data_width-1];
    assign y_neg = ~sel_unsigned & sel_y[data_width-1];

    // most negative value maps onto 2^31, still fits unsigned
    assign x_mag = x_neg ? -sel_x : sel_x;
    assign y_mag = y_neg ? -sel_y : sel_y;

    assign go       = sel_div;
    assign op       = sel_mod ? op_rem : op_quot;
    assign dividend = sel_x;

    // quotient sign from both operands, remainder follows the dividend
    assign q_neg = x_neg ^ y_neg;
    assign r_neg = x_neg;

endmodule

`default_nettype wire

//--- design/srt_core.sv
// buffer stage: radix-2 SRT iteration on operand magnitudes, returns quotient and remainder magnitudes
`timescale 1ns/1ns
`default_nettype none

module srt_core import div_pkg::*; (
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  go,
    input  div_op_t               op,
    input  logic [data_width-1:0] x_mag,
    input  logic [data_width-1:0] y_mag,
    input  logic [data_width-1:0] dividend,
    input  logic                  q_neg,
    input  logic                  r_neg,
    output logic                  complete,
    output logic                  zero_div,
    output logic [data_width-1:0] quot_mag,
    output logic [data_width-1:0] rem_mag,
    output div_op_t               op_hold,
    output logic                  q_neg_hold,
    output logic                  r_neg_hold
);

    srt_state_t state;

    // partial remainder and divisor carry one sign bit above the data
    logic [data_width:0]    part_rem;
    logic [data_width:0]    divisor;
    logic [data_width:0]    neg_divisor;
    logic [data_width:0]    divisor_negated;
    logic [data_width:0]    rem_plus_d;
    logic [data_width:0]    rem_minus_d;
    logic [data_width:0]    digit_sum;
    logic [data_width:0]    rem_fixed;
    logic [data_width:0]    rem_shifted;
    logic [data_width-1:0]  pos_q;
    logic [data_width-1:0]  neg_q;
    logic [data_width-1:0]  quot_fixed;
    logic                   pos_bit;
    logic                   neg_bit;
    logic                   last_round;
    logic [count_width-1:0] counter;
    logic [count_width-1:0] rounds;
    logic [count_width-1:0] shifter;
    logic [count_width-1:0] back_shift;
    logic [count_width-1:0] rem_zeros;
    logic [count_width-1:0] div_zeros;
    logic [count_width-1:0] zero_delta;

    leading_zero_count u_lzc_rem (
        .data       (part_rem[data_width-1:0]),
        .zero_count (rem_zeros)
    );

    leading_zero_count u_lzc_div (
        .data       (divisor[data_width-1:0]),
        .zero_count (div_zeros)
    );

    // negative when the dividend has more leading zeros
    assign zero_delta      = div_zeros - rem_zeros;
    assign divisor_negated = -divisor;
    assign rem_plus_d      = part_rem + divisor;
    assign rem_minus_d     = part_rem + neg_divisor;
    assign last_round      = (counter == rounds);

    // digit from the top two bits: 01 -> +1, 10 -> -1, else 0
    always_comb begin
        digit_sum = part_rem;
        pos_bit   = 1'b0;
        neg_bit   = 1'b0;
        case (part_rem[data_width:data_width-1])
            2'b01: begin
                digit_sum = rem_minus_d;
                pos_bit   = 1'b1;
            end
            2'b10: begin
                digit_sum = rem_plus_d;
                neg_bit   = 1'b1;
            end
            default: begin
                digit_sum = part_rem;
            end
        endcase
    end

    // negative final remainder costs one quotient ulp
    assign rem_fixed   = part_rem[data_width] ? rem_plus_d : part_rem;
    assign quot_fixed  = pos_q - neg_q - {{(data_width-1){1'b0}}, part_rem[data_width]};
    assign back_shift  = rounds + shifter;
    assign rem_shifted = rem_fixed >> back_shift;

    // datapath
    always_ff @(posedge clk) begin
        if (go) begin
            case (state)
                st_waiting: begin
                    part_rem <= {1'b0, x_mag};
                    divisor  <= {1'b0, y_mag};
                end
                st_normalize: begin
                    part_rem    <= part_rem << rem_zeros;
                    divisor     <= divisor << div_zeros;
                    neg_divisor <= divisor_negated << div_zeros;
                    pos_q       <= '0;
                    neg_q       <= '0;
                    shifter     <= rem_zeros;
                    counter     <= '0;
                    rounds      <= zero_delta;
                end
                st_dividing: begin
                    // no shift after the last digit
                    if (last_round) begin
                        part_rem <= digit_sum;
                    end else begin
                        part_rem <= {digit_sum[data_width-1:0], 1'b0};
                    end
                    pos_q   <= {pos_q[data_width-2:0], pos_bit};
                    neg_q   <= {neg_q[data_width-2:0], neg_bit};
                    counter <= counter + 1'b1;
                end
                default: begin
                    counter <= counter;
                end
            endcase
        end
    end

    // sequencing and results
    always_ff @(posedge clk) begin
        if (reset) begin
            state      <= st_waiting;
            complete   <= 1'b0;
            zero_div   <= 1'b0;
            quot_mag   <= '0;
            rem_mag    <= '0;
            op_hold    <= op_quot;
            q_neg_hold <= 1'b0;
            r_neg_hold <= 1'b0;
        end else if (complete) begin
            // result shown for one cycle only
            complete <= 1'b0;
            zero_div <= 1'b0;
            state    <= st_waiting;
        end else if (go) begin
            case (state)
                st_waiting: begin
                    op_hold    <= op;
                    q_neg_hold <= q_neg;
                    r_neg_hold <= r_neg;
                    state      <= st_normalize;
                end
                st_normalize: begin
                    if (div_zeros == count_width'(data_width)) begin
                        zero_div <= 1'b1;
                        complete <= 1'b1;
                        state    <= st_waiting;
                    end else if (zero_delta[count_width-1]) begin
                        // raw dividend already carries its sign
                        quot_mag   <= '0;
                        rem_mag    <= dividend;
                        r_neg_hold <= 1'b0;
                        complete   <= 1'b1;
                        state      <= st_waiting;
                    end else begin
                        state <= st_dividing;
                    end
                end
                st_dividing: begin
                    if (last_round) begin
                        state <= st_finished;
                    end
                end
                st_finished: begin
                    quot_mag <= quot_fixed;
                    rem_mag  <= rem_shifted[data_width-1:0];
                    complete <= 1'b1;
                    state    <= st_waiting;
                end
                default: begin
                    state <= st_waiting;
                end
            endcase
        end
    end

endmodule

`default_nettype wire

//--- design/div_result_fixup.sv
// consumer stage: applies result signs, selects quotient or remainder and forms div_ok
`timescale 1ns/1ns
`default_nettype none

module div_result_fixup import div_pkg::*; (
    input  logic                  go,
    input  logic                  complete,
    input  logic                  zero_div,
    input  logic [data_width-1:0] quot_mag,
    input  logic [data_width-1:0] rem_mag,
    input  logic [data_width-1:0] dividend,
    input  div_op_t               op_hold,
    input  logic                  q_neg_hold,
    input  logic                  r_neg_hold,
    output logic [data_width-1:0] result,
    output logic                  div_ok,
    output logic                  div_zero
);

    logic [data_width-1:0] quot_signed;
    logic [data_width-1:0] rem_signed;

    assign quot_signed = q_neg_hold ? -quot_mag : quot_mag;
    assign rem_signed  = r_neg_hold ? -rem_mag : rem_mag;

    always_comb begin
        if (zero_div) begin
            // divide by zero: all ones or the untouched dividend
            if (op_hold == op_quot) begin
                result = '1;
            end else begin
                result = dividend;
            end
        end else if (op_hold == op_rem) begin
            result = rem_signed;
        end else begin
            result = quot_signed;
        end
    end

    // idle unit reads as ok
    assign div_ok   = complete | ~go;
    assign div_zero = zero_div;

endmodule

`default_nettype wire

//--- design/div_unit.sv
// top of the integer divide unit shared by both execute slots
`timescale 1ns/1ns
`default_nettype none

module div_unit import div_pkg::*; (
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  req1_div,
    input  logic                  req1_mod,
    input  logic                  req1_unsigned,
    input  logic [data_width-1:0] req1_x,
    input  logic [data_width-1:0] req1_y,
    input  logic                  req2_div,
    input  logic                  req2_mod,
    input  logic                  req2_unsigned,
    input  logic [data_width-1:0] req2_x,
    input  logic [data_width-1:0] req2_y,
    output logic [data_width-1:0] result,
    output logic                  div_ok,
    output logic                  div_zero
);

    logic                  go;
    div_op_t               op;
    logic [data_width-1:0] x_mag;
    logic [data_width-1:0] y_mag;
    logic [data_width-1:0] dividend;
    logic                  q_neg;
    logic                  r_neg;
    logic                  complete;
    logic                  zero_div;
    logic [data_width-1:0] quot_mag;
    logic [data_width-1:0] rem_mag;
    div_op_t               op_hold;
    logic                  q_neg_hold;
    logic                  r_neg_hold;

    div_request_select u_select (
        .req1_div      (req1_div),
        .req1_mod      (req1_mod),
        .req1_unsigned (req1_unsigned),
        .req1_x        (req1_x),
        .req1_y        (req1_y),
        .req2_div      (req2_div),
        .req2_mod      (req2_mod),
        .req2_unsigned (req2_unsigned),
        .req2_x        (req2_x),
        .req2_y        (req2_y),
        .go            (go),
        .op            (op),
        .x_mag         (x_mag),
        .y_mag         (y_mag),
        .dividend      (dividend),
        .q_neg         (q_neg),
        .r_neg         (r_neg)
    );

    srt_core u_core (
        .clk        (clk),
        .reset      (reset),
        .go         (go),
        .op         (op),
        .x_mag      (x_mag),
        .y_mag      (y_mag),
        .dividend   (dividend),
        .q_neg      (q_neg),
        .r_neg      (r_neg),
        .complete   (complete),
        .zero_div   (zero_div),
        .quot_mag   (quot_mag),
        .rem_mag    (rem_mag),
        .op_hold    (op_hold),
        .q_neg_hold (q_neg_hold),
        .r_neg_hold (r_neg_hold)
    );

    div_result_fixup u_fixup (
        .go         (go),
        .complete   (complete),
        .zero_div   (zero_div),
        .quot_mag   (quot_mag),
        .rem_mag    (rem_mag),
        .dividend   (dividend),
        .op_hold    (op_hold),
        .q_neg_hold (q_neg_hold),
        .r_neg_hold (r_neg_hold),
        .result     (result),
        .div_ok     (div_ok),
        .div_zero   (div_zero)
    );

endmodule

`default_nettype wire

//--- sim/div_unit_tb.sv
// testbench for div_unit, runs directed cases from the stimulus file and then seeded random cases
`timescale 1ns/1ns
`default_nettype none

module div_unit_tb import div_pkg::*; ();

    localparam int directed_cases = 18;
    localparam int random_cases   = 16;
    localparam int reset_cycles   = 4;
    // drive edge, up to 36 busy cycles, one idle cycle
    localparam int case_cycles    = 38;
    localparam int cycle_limit    =
        ((directed_cases + random_cases) * case_cycles + reset_cycles) * 5 / 4;
    localparam int max_rows       = 64;

    logic                  clk;
    logic                  reset;
    logic                  req1_div;
    logic                  req1_mod;
    logic                  req1_unsigned;
    logic [data_width-1:0] req1_x;
    logic [data_width-1:0] req1_y;
    logic                  req2_div;
    logic                  req2_mod;
    logic                  req2_unsigned;
    logic [data_width-1:0] req2_x;
    logic [data_width-1:0] req2_y;
    logic [data_width-1:0] result;
    logic                  div_ok;
    logic                  div_zero;

    logic [31:0] stim [0:7*max_rows-1];
    logic [31:0] rng;
    int          passed;
    int          failed;
    int          case_num;
    int          cycles = 0;

    div_unit i_dut (.*);

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= cycle_limit) begin
            $display("timeout: the divider never signalled completion within %0d cycles",
                cycle_limit);
            $display("Regression failed");
            $finish;
        end
    end

    function automatic logic [31:0] lcg_next(input logic [31:0] state);
        return state * 32'd1664525 + 32'd1013904223;
    endfunction

    // truncating division, remainder follows the dividend sign, bit 32 is div_zero
    function automatic logic [32:0] expected_result(input logic mod, input logic uns,
            input logic [31:0] x, input logic [31:0] y);
        logic        x_neg;
        logic        y_neg;
        logic [31:0] xm;
        logic [31:0] ym;
        logic [31:0] qm;
        logic [31:0] rm;
        if (y == 32'd0) begin
            return {1'b1, mod ? x : 32'hffffffff};
        end
        x_neg = !uns && x[31];
        y_neg = !uns && y[31];
        xm    = x_neg ? -x : x;
        ym    = y_neg ? -y : y;
        qm    = xm / ym;
        rm    = xm % ym;
        if (mod) begin
            return {1'b0, x_neg ? -rm : rm};
        end
        return {1'b0, (x_neg ^ y_neg) ? -qm : qm};
    endfunction

    task automatic check_word(input string name, input logic [31:0] got,
            input logic [31:0] want, inout logic ok);
        assert (got === want) else begin
            $display("CHECK FAILED %s: expected %h got %h", name, want, got);
            ok = 1'b0;
        end
    endtask

    task automatic log_case(input string what, input logic ok);
        case_num++;
        if (ok) begin
            passed++;
        end else begin
            failed++;
        end
        $display("case %0d %s: %s", case_num, what, ok ? "ok" : "FAILED");
    endtask

    task automatic check_idle();
        logic ok;
        ok = 1'b1;
        @(negedge clk);
        check_word("div_ok", {31'd0, div_ok}, 32'd1, ok);
        check_word("div_zero", {31'd0, div_zero}, 32'd0, ok);
        check_word("result", result, 32'd0, ok);
        log_case("idle after reset", ok);
    endtask

    task automatic run_case(input string kind, input logic [1:0] mask, input logic mod,
            input logic uns, input logic [31:0] x, input logic [31:0] y,
            input logic [31:0] want, input logic want_zero);
        logic ok;
        ok = 1'b1;
        @(posedge clk);
        // the slot that should not win asks for something different
        req1_div      <= mask[0];
        req1_mod      <= mask[0] ? mod : ~mod;
        req1_unsigned <= uns;
        req1_x        <= mask[0] ? x : y;
        req1_y        <= mask[0] ? y : x;
        req2_div      <= mask[1];
        req2_mod      <= mask[0] ? ~mod : mod;
        req2_unsigned <= uns;
        req2_x        <= mask[0] ? y : x;
        req2_y        <= mask[0] ? x : y;
        @(negedge clk);
        while (!(div_ok && (req1_div || req2_div))) begin
            @(negedge clk);
        end
        check_word("result", result, want, ok);
        check_word("div_zero", {31'd0, div_zero}, {31'd0, want_zero}, ok);
        log_case($sformatf("%s slots %0d mod %0d unsigned %0d x %h y %h",
            kind, mask, mod, uns, x, y), ok);
        @(posedge clk);
        req1_div <= 1'b0;
        req2_div <= 1'b0;
    endtask

    task automatic run_directed();
        int rows;
        rows = 0;
        for (int i = 0; i < 7 * max_rows; i++) begin
            stim[i] = '0;
        end
        $readmemh("sim/div_stimulus.txt", stim);
        // a zero slot mask ends the table
        while (rows < max_rows && stim[7*rows] inside {32'd1, 32'd2, 32'd3}) begin
            run_case("directed", stim[7*rows][1:0], stim[7*rows+1][0], stim[7*rows+2][0],
                stim[7*rows+3], stim[7*rows+4], stim[7*rows+5], stim[7*rows+6][0]);
            rows++;
        end
        if (rows == 0) begin
            $display("no directed cases could be read from the stimulus file");
            failed++;
        end
    endtask

    task automatic run_random();
        logic [1:0]  mask;
        logic        mod;
        logic        uns;
        logic [31:0] x;
        logic [31:0] y;
        logic [32:0] want;
        for (int i = 0; i < random_cases; i++) begin
            rng  = lcg_next(rng);
            mask = (rng[17:16] == 2'd0) ? 2'd1 : rng[17:16];
            mod  = rng[20];
            uns  = rng[21];
            rng  = lcg_next(rng);
            x    = rng;
            rng  = lcg_next(rng);
            // vary divisor width so the round count moves around
            y    = rng >> rng[28:24];
            want = expected_result(mod, uns, x, y);
            run_case("random", mask, mod, uns, x, y, want[31:0], want[32]);
        end
    endtask

    initial begin
        reset         = 1'b1;
        req1_div      = 1'b0;
        req1_mod      = 1'b0;
        req1_unsigned = 1'b0;
        req1_x        = '0;
        req1_y        = '0;
        req2_div      = 1'b0;
        req2_mod      = 1'b0;
        req2_unsigned = 1'b0;
        req2_x        = '0;
        req2_y        = '0;
        rng           = 32'h677c;
        passed        = 0;
        failed        = 0;
        case_num      = 0;
        repeat (reset_cycles) @(posedge clk);
        reset <= 1'b0;
        check_idle();
        run_directed();
        run_random();
        $display("summary: %0d cases passed, %0d cases failed", passed, failed);
        if (failed == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- sim.f
design/div_pkg.sv
design/leading_zero_count.sv
design/div_request_select.sv
design/srt_core.sv
design/div_result_fixup.sv
design/div_unit.sv
sim/div_unit_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert --top-module div_unit_tb -f sim.f \
    || { echo "verilator build failed"; exit 1; }
output="$(./obj_dir/Vdiv_unit_tb)"
echo "$output"
echo "$output" | grep -qx "Regression passed" && exit 0 || exit 1

//--- sim/div_stimulus.txt
// slots mod unsigned x y expected_result expected_div_zero, all hex
// slots 1 = slot 1, 2 = slot 2, 3 = both with swapped operands and flipped mod on slot 2
1 0 1 00000064 00000007 0000000e 0
1 1 1 00000064 00000007 00000002 0
1 0 1 ffffffff 00000001 ffffffff 0
1 0 1 80000000 00000010 08000000 0
1 0 1 ffffffff 00010000 0000ffff 0
1 0 0 ffffff9c 00000007 fffffff2 0
1 1 0 ffffff9c 00000007 fffffffe 0
1 0 0 00000064 fffffff9 fffffff2 0
1 1 0 00000064 fffffff9 00000002 0
1 0 0 ffffff9c fffffff9 0000000e 0
1 0 0 80000000 ffffffff 80000000 0
1 1 0 80000000 ffffffff 00000000 0
1 0 1 12345678 00000000 ffffffff 1
2 1 0 ffffff9c 00000000 ffffff9c 1
1 0 1 00000005 00000064 00000000 0
1 1 0 fffffffb 00000064 fffffffb 0
3 0 1 000003e8 0000000a 00000064 0
3 1 0 fffffc18 00000007 fffffffa 0
